// ==== files.f ====
+incdir+tb
common/exe_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/mul_unit.sv
verilog/div_unit.sv
exe/exe_top.sv
tb/tb_exe_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execution-stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_exe_top -o tb_exe_top \
    && ./obj_dir/tb_exe_top \
    || { echo "Simulation run reported an error"; exit 1; }

echo "Simulation run completed"

// ==== tb/tb_exe_tasks.svh ====
`ifndef TB_EXE_TASKS_SVH
`define TB_EXE_TASKS_SVH

// ----------------------------------------
// Reporting
// ----------------------------------------

task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("*** FAILED ***");
    $fatal(1);
endtask

task automatic check_value(input string name, input bus64_t actual, input bus64_t expected);
    if (actual !== expected) begin
        $display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
        abort_run("a DUT output differs from the reference model");
    end
endtask

// ----------------------------------------
// Reference models
// ----------------------------------------

function automatic bus64_t rand64();
    return {$random(seed), $random(seed)};
endfunction

function automatic bus64_t fwd_value(reg_t r, bus64_t rr_data, wb_exe_instr_t wb);
    if (wb.valid && r != 5'd0 && r == wb.rd) begin
        return wb.data;
    end
    return rr_data;
endfunction

// Two's complement order from the sign bits, then the magnitudes
function automatic logic less_signed(bus64_t a, bus64_t b);
    if (a[63] != b[63]) begin
        return a[63];
    end
    return a < b;
endfunction

function automatic bus64_t alu_model(instr_type_e op, bus64_t a, bus64_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
        ADD:     return a + b;
        SUB:     return a - b;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLL:     return a << sh;
        SRL:     return a >> sh;
        // Negative values shift in ones
        SRA:     return a[63] ? ~(~a >> sh) : (a >> sh);
        SLT:     return less_signed(a, b) ? 64'd1 : 64'd0;
        SLTU:    return (a < b) ? 64'd1 : 64'd0;
        default: return '0;
    endcase
endfunction

// Full 128-bit product of the sign- or zero-extended operands
function automatic bus64_t mul_model(instr_type_e op, bus64_t a, bus64_t b);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] p;
    ea = {64'd0, a};
    eb = {64'd0, b};
    if (op == MULH || op == MULHSU) begin
        ea = {{64{a[63]}}, a};
    end
    if (op == MULH) begin
        eb = {{64{b[63]}}, b};
    end
    p = ea * eb;
    return (op == MUL) ? p[63:0] : p[127:64];
endfunction

function automatic bus64_t div_model(instr_type_e op, bus64_t a, bus64_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    if (b == '0) begin
        return (op == DIV || op == DIVU) ? {XLEN{1'b1}} : a;
    end
    if (op == DIV || op == REM) begin
        // Signed overflow case
        if (a == {1'b1, 63'd0} && b == {XLEN{1'b1}}) begin
            return (op == DIV) ? a : '0;
        end
        return (op == DIV) ? bus64_t'(sa / sb) : bus64_t'(sa % sb);
    end
    return (op == DIVU) ? a / b : a % b;
endfunction

function automatic logic branch_cond(instr_type_e op, bus64_t a, bus64_t b);
    case (op)
        BEQ:     return a == b;
        BNE:     return a != b;
        BLT:     return less_signed(a, b);
        BGE:     return !less_signed(a, b);
        BLTU:    return a < b;
        BGEU:    return a >= b;
        default: return 1'b1;
    endcase
endfunction

function automatic exe_wb_instr_t expected_result(rr_exe_instr_t pkt, wb_exe_instr_t wb);
    exe_wb_instr_t e;
    instr_type_e   op;
    bus64_t        a;
    bus64_t        b;
    bus64_t        s1;
    bus64_t        s2;
    addr_pc_t      pc4;
    addr_pc_t      target;
    op  = pkt.instr.instr_type;
    a   = fwd_value(pkt.instr.rs1, pkt.data_rs1, wb);
    b   = fwd_value(pkt.instr.rs2, pkt.data_rs2, wb);
    s1  = pkt.instr.use_pc ? pkt.instr.pc : a;
    s2  = pkt.instr.use_imm ? pkt.instr.imm : b;
    pc4 = pkt.instr.pc + 64'd4;
    e       = '0;
    e.valid = 1'b1;
    e.rd    = pkt.instr.rd;
    case (pkt.instr.unit)
        UNIT_ALU:    e.result_rd = alu_model(op, s1, s2);
        UNIT_MUL:    e.result_rd = mul_model(op, a, b);
        UNIT_DIV:    e.result_rd = div_model(op, a, s2);
        UNIT_SYSTEM: e.result_rd = a;
        UNIT_BRANCH: begin
            if (op == JALR) begin
                target = (a + pkt.instr.imm) & ~64'd1;
            end else begin
                target = pkt.instr.pc + pkt.instr.imm;
            end
            e.branch_taken = branch_cond(op, a, b);
            e.result_pc    = e.branch_taken ? target : pc4;
            e.result_rd    = (op == JAL || op == JALR) ? pc4 : '0;
        end
        default:     e.result_rd = '0;
    endcase
    return e;
endfunction

// ----------------------------------------
// Driver
// ----------------------------------------

function automatic rr_exe_instr_t make_instr(unit_e fu, instr_type_e op, logic use_imm);
    rr_exe_instr_t p;
    logic [11:0]   r12;
    r12 = 12'($random(seed));
    p = '0;
    p.instr.valid      = 1'b1;
    p.instr.pc         = rand64() & ~64'h3;
    p.instr.rs1        = reg_t'($random(seed)) | 5'd1;
    p.instr.rs2        = reg_t'($random(seed)) | 5'd1;
    p.instr.rd         = reg_t'($random(seed));
    p.instr.imm        = {{52{r12[11]}}, r12};
    p.instr.use_imm    = use_imm;
    p.instr.unit       = fu;
    p.instr.instr_type = op;
    p.data_rs1         = rand64();
    p.data_rs2         = rand64();
    return p;
endfunction

// Holds the packet while stalled and returns the completion-cycle output
task automatic issue_instr(input rr_exe_instr_t pkt, input wb_exe_instr_t wb,
                           output exe_wb_instr_t res, output int stalls);
    stalls = 0;
    @(negedge clk_i);
    from_rr_i = pkt;
    from_wb_i = wb;
    #(CLK_PERIOD / 4);
    while (stall_o) begin
        check_value("to_wb_o.valid while stalled", 64'(to_wb_o.valid), 64'd0);
        stalls++;
        @(negedge clk_i);
        #(CLK_PERIOD / 4);
    end
    res = to_wb_o;
endtask

// A negative exp_stalls only asks for some stall
task automatic run_and_check(input rr_exe_instr_t pkt, input wb_exe_instr_t wb,
                             input int exp_stalls);
    exe_wb_instr_t want;
    exe_wb_instr_t got;
    int            stalls;
    want = expected_result(pkt, wb);
    issue_instr(pkt, wb, got, stalls);
    check_value("to_wb_o.valid", 64'(got.valid), 64'(want.valid));
    check_value("to_wb_o.rd", 64'(got.rd), 64'(want.rd));
    check_value("to_wb_o.result_rd", got.result_rd, want.result_rd);
    check_value("to_wb_o.result_pc", got.result_pc, want.result_pc);
    check_value("to_wb_o.branch_taken", 64'(got.branch_taken), 64'(want.branch_taken));
    if (exp_stalls >= 0) begin
        check_value("stall_o cycles", 64'(stalls), 64'(exp_stalls));
    end else if (stalls == 0) begin
        abort_run("the divider finished without raising stall_o");
    end
endtask

`endif

// ==== tb/tb_exe_top.sv ====
`timescale 1ns/1ps

module tb_exe_top import exe_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 80;

    logic          clk_i;
    logic          rst_n_i;
    logic          kill_i;
    rr_exe_instr_t from_rr_i;
    wb_exe_instr_t from_wb_i;
    exe_wb_instr_t to_wb_o;
    logic          stall_o;
    integer        seed;

    exe_top exe_top_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .kill_i    (kill_i),
        .from_rr_i (from_rr_i),
        .from_wb_i (from_wb_i),
        .to_wb_o   (to_wb_o),
        .stall_o   (stall_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    `include "tb_exe_tasks.svh"

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_reset();
        @(negedge clk_i);
        #(CLK_PERIOD / 4);
        check_value("stall_o after reset", 64'(stall_o), 64'd0);
        check_value("to_wb_o.valid after reset", 64'(to_wb_o.valid), 64'd0);
        // A first multiply finds the units idle
        run_and_check(make_instr(UNIT_MUL, MULHU, 1'b0), '0, MUL_LATENCY);
    endtask

    task automatic test_alu();
        instr_type_e   op;
        rr_exe_instr_t p;
        op = ADD;
        // Register form, then immediate form
        repeat (10) begin
            p = make_instr(UNIT_ALU, op, 1'b0);
            run_and_check(p, '0, 0);
            p = make_instr(UNIT_ALU, op, 1'b1);
            run_and_check(p, '0, 0);
            op = op.next();
        end
        // PC plus immediate
        p = make_instr(UNIT_ALU, ADD, 1'b1);
        p.instr.use_pc = 1'b1;
        run_and_check(p, '0, 0);
    endtask

    task automatic test_forwarding();
        rr_exe_instr_t p;
        wb_exe_instr_t wb;
        p = make_instr(UNIT_ALU, SUB, 1'b0);
        p.instr.rs1 = 5'd7;
        p.instr.rs2 = 5'd9;
        wb.valid    = 1'b1;
        wb.rd       = 5'd7;
        wb.data     = rand64();
        run_and_check(p, wb, 0);
        wb.rd = 5'd9;
        run_and_check(p, wb, 0);
        // Both operands from write-back
        p.instr.rs2 = 5'd7;
        wb.rd       = 5'd7;
        run_and_check(p, wb, 0);
        // x0 is never forwarded
        p.instr.rs1 = 5'd0;
        p.instr.rs2 = 5'd0;
        wb.rd       = 5'd0;
        run_and_check(p, wb, 0);
        p.instr.rs1 = 5'd7;
        wb.rd       = 5'd7;
        wb.valid    = 1'b0;
        run_and_check(p, wb, 0);
    endtask

    task automatic test_branch();
        instr_type_e   op;
        rr_exe_instr_t p;
        bus64_t        tmp;
        op = BEQ;
        // Equal, then distinct operands in both orders
        repeat (6) begin
            p = make_instr(UNIT_BRANCH, op, 1'b0);
            p.data_rs2 = p.data_rs1;
            run_and_check(p, '0, 0);
            p = make_instr(UNIT_BRANCH, op, 1'b0);
            run_and_check(p, '0, 0);
            tmp        = p.data_rs1;
            p.data_rs1 = p.data_rs2;
            p.data_rs2 = tmp;
            run_and_check(p, '0, 0);
            op = op.next();
        end
        p = make_instr(UNIT_BRANCH, JAL, 1'b0);
        run_and_check(p, '0, 0);
        // Odd sum so bit 0 must drop
        p = make_instr(UNIT_BRANCH, JALR, 1'b0);
        p.data_rs1  = rand64() | 64'd1;
        p.instr.imm = 64'd0;
        run_and_check(p, '0, 0);
        p = make_instr(UNIT_BRANCH, JALR, 1'b0);
        run_and_check(p, '0, 0);
    endtask

    task automatic test_mul();
        instr_type_e   op;
        rr_exe_instr_t p;
        op = MUL;
        repeat (4) begin
            p = make_instr(UNIT_MUL, op, 1'b0);
            run_and_check(p, '0, MUL_LATENCY);
            p.data_rs1 = {1'b1, 63'd0};
            p.data_rs2 = {1'b1, 63'd0};
            run_and_check(p, '0, MUL_LATENCY);
            p.data_rs1 = {XLEN{1'b1}};
            p.data_rs2 = {1'b0, {(XLEN-1){1'b1}}};
            run_and_check(p, '0, MUL_LATENCY);
            op = op.next();
        end
    endtask

    task automatic test_div();
        instr_type_e   op;
        rr_exe_instr_t p;
        op = DIV;
        repeat (4) begin
            // Smaller divisor for a wider quotient
            p = make_instr(UNIT_DIV, op, 1'b0);
            p.data_rs2 = p.data_rs2 >> p.data_rs2[4:0];
            run_and_check(p, '0, -1);
            p.data_rs2 = '0;
            run_and_check(p, '0, -1);
            p.data_rs1 = {1'b1, 63'd0};
            p.data_rs2 = {XLEN{1'b1}};
            run_and_check(p, '0, -1);
            op = op.next();
        end
    endtask

    task automatic test_kill();
        rr_exe_instr_t p;
        wb_exe_instr_t wb;
        p = make_instr(UNIT_DIV, DIVU, 1'b0);
        @(negedge clk_i);
        from_rr_i = p;
        from_wb_i = '0;
        #(CLK_PERIOD / 4);
        check_value("stall_o in division", 64'(stall_o), 64'd1);
        repeat (4) @(negedge clk_i);
        kill_i = 1'b1;
        #(CLK_PERIOD / 4);
        check_value("to_wb_o.valid under kill", 64'(to_wb_o.valid), 64'd0);
        // Upstream drops the killed instruction
        @(negedge clk_i);
        kill_i    = 1'b0;
        from_rr_i = '0;
        #(CLK_PERIOD / 4);
        check_value("stall_o after kill", 64'(stall_o), 64'd0);
        check_value("to_wb_o.valid after kill", 64'(to_wb_o.valid), 64'd0);
        run_and_check(make_instr(UNIT_ALU, XOR, 1'b0), '0, 0);
        run_and_check(make_instr(UNIT_DIV, REM, 1'b0), '0, -1);
        p = make_instr(UNIT_SYSTEM, ADD, 1'b0);
        wb.valid = 1'b1;
        wb.rd    = p.instr.rs1;
        wb.data  = rand64();
        run_and_check(p, wb, 0);
        // Kill drops an ALU result in its own cycle
        @(negedge clk_i);
        from_rr_i = make_instr(UNIT_ALU, ADD, 1'b0);
        kill_i    = 1'b1;
        #(CLK_PERIOD / 4);
        check_value("to_wb_o.valid with ALU under kill", 64'(to_wb_o.valid), 64'd0);
        @(negedge clk_i);
        kill_i    = 1'b0;
        from_rr_i = '0;
    endtask

    // ----------------------------------------
    // Sequence and watchdog
    // ----------------------------------------

    initial begin
        seed      = 96616;
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        kill_i    = 1'b0;
        from_rr_i = '0;
        from_wb_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        test_reset();
        test_alu();
        test_forwarding();
        test_branch();
        test_mul();
        test_div();
        test_kill();
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * (DIV_STEPS + 10) + RESET_CYCLES));
        $display("Timeout: the test sequence did not finish in the allowed time");
        $display("*** FAILED ***");
        $fatal(1);
    end

endmodule

// ==== exe/exe_top.sv ====
`timescale 1ns/1ps

module exe_top import exe_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          kill_i,
    input  rr_exe_instr_t from_rr_i,
    input  wb_exe_instr_t from_wb_i,
    output exe_wb_instr_t to_wb_o,
    output logic          stall_o
);

    bus64_t   rs1_fwd;
    bus64_t   rs2_fwd;
    bus64_t   src1;
    bus64_t   src2;

    bus64_t   alu_result;
    logic     br_taken;
    addr_pc_t br_next_pc;
    bus64_t   br_link;

    bus64_t   mul_result;
    logic     mul_busy;
    logic     mul_done;
    logic     mul_req;
    logic     mul_started_q;

    bus64_t   div_quotient;
    bus64_t   div_remainder;
    logic     div_busy;
    logic     div_done;
    logic     div_req;
    logic     div_started_q;

    logic     is_mul;
    logic     is_div;

    // ----------------------------------------
    // Forwarding and source select
    // ----------------------------------------

    // x0 never takes a forwarded value
    assign rs1_fwd = (from_wb_i.valid && (from_rr_i.instr.rs1 != '0) &&
                      (from_rr_i.instr.rs1 == from_wb_i.rd)) ? from_wb_i.data
                                                            : from_rr_i.data_rs1;
    assign rs2_fwd = (from_wb_i.valid && (from_rr_i.instr.rs2 != '0) &&
                      (from_rr_i.instr.rs2 == from_wb_i.rd)) ? from_wb_i.data
                                                            : from_rr_i.data_rs2;

    assign src1 = from_rr_i.instr.use_pc  ? from_rr_i.instr.pc  : rs1_fwd;
    assign src2 = from_rr_i.instr.use_imm ? from_rr_i.instr.imm : rs2_fwd;

    // ----------------------------------------
    // Multi-cycle unit requests
    // ----------------------------------------

    assign is_mul = from_rr_i.instr.valid && (from_rr_i.instr.unit == UNIT_MUL);
    assign is_div = from_rr_i.instr.valid && (from_rr_i.instr.unit == UNIT_DIV);

    // A held instruction starts its unit only once
    assign mul_req = is_mul && !mul_started_q && !mul_busy && !kill_i;
    assign div_req = is_div && !div_started_q && !div_busy && !kill_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mul_started_q <= 1'b0;
            div_started_q <= 1'b0;
        end else begin
            if (kill_i || mul_done) begin
                mul_started_q <= 1'b0;
            end else if (mul_req) begin
                mul_started_q <= 1'b1;
            end
            if (kill_i || div_done) begin
                div_started_q <= 1'b0;
            end else if (div_req) begin
                div_started_q <= 1'b1;
            end
        end
    end

    // Hold upstream until the unit reports done
    assign stall_o = (is_mul && !mul_done) || (is_div && !div_done);

    // ----------------------------------------
    // Units
    // ----------------------------------------

    alu alu_inst (
        .src1_i       (src1),
        .src2_i       (src2),
        .instr_type_i (from_rr_i.instr.instr_type),
        .result_o     (alu_result)
    );

    branch_unit branch_unit_inst (
        .instr_type_i (from_rr_i.instr.instr_type),
        .pc_i         (from_rr_i.instr.pc),
        .rs1_i        (rs1_fwd),
        .rs2_i        (rs2_fwd),
        .imm_i        (from_rr_i.instr.imm),
        .taken_o      (br_taken),
        .next_pc_o    (br_next_pc),
        .link_o       (br_link)
    );

    mul_unit mul_unit_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .kill_i       (kill_i),
        .request_i    (mul_req),
        .instr_type_i (from_rr_i.instr.instr_type),
        .src1_i       (rs1_fwd),
        .src2_i       (rs2_fwd),
        .result_o     (mul_result),
        .busy_o       (mul_busy),
        .done_o       (mul_done)
    );

    div_unit div_unit_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .kill_i       (kill_i),
        .request_i    (div_req),
        .instr_type_i (from_rr_i.instr.instr_type),
        .dividend_i   (rs1_fwd),
        .divisor_i    (src2),
        .quotient_o   (div_quotient),
        .remainder_o  (div_remainder),
        .busy_o       (div_busy),
        .done_o       (div_done)
    );

    // ----------------------------------------
    // Result to write-back
    // ----------------------------------------

    always_comb begin
        to_wb_o.valid        = from_rr_i.instr.valid && !stall_o && !kill_i;
        to_wb_o.rd           = from_rr_i.instr.rd;
        to_wb_o.result_pc    = '0;
        to_wb_o.branch_taken = 1'b0;
        case (from_rr_i.instr.unit)
            UNIT_ALU:    to_wb_o.result_rd = alu_result;
            UNIT_MUL:    to_wb_o.result_rd = mul_result;
            UNIT_DIV: begin
                if (from_rr_i.instr.instr_type == REM || from_rr_i.instr.instr_type == REMU) begin
                    to_wb_o.result_rd = div_remainder;
                end else begin
                    to_wb_o.result_rd = div_quotient;
                end
            end
            UNIT_BRANCH: begin
                to_wb_o.result_rd    = br_link;
                to_wb_o.result_pc    = br_next_pc;
                to_wb_o.branch_taken = br_taken;
            end
            UNIT_SYSTEM: to_wb_o.result_rd = rs1_fwd;
            default:     to_wb_o.result_rd = '0;
        endcase
    end

endmodule

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ps

module div_unit import exe_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        kill_i,
    input  logic        request_i,
    input  instr_type_e instr_type_i,
    input  bus64_t      dividend_i,
    input  bus64_t      divisor_i,
    output bus64_t      quotient_o,
    output bus64_t      remainder_o,
    output logic        busy_o,
    output logic        done_o
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] cnt_q;

    logic                 signed_op;
    logic                 dvnd_neg;
    logic                 dvsr_neg;

    bus64_t               rem_q;
    bus64_t               quo_q;
    bus64_t               dvsr_q;
    logic                 q_neg_q;
    logic                 r_neg_q;

    logic [XLEN:0]        partial;
    logic [XLEN:0]        diff;
    logic                 fits;

    assign signed_op = (instr_type_i == DIV) || (instr_type_i == REM);
    assign dvnd_neg  = signed_op && dividend_i[XLEN-1];
    assign dvsr_neg  = signed_op && divisor_i[XLEN-1];

    // ----------------------------------------
    // Control
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (request_i) begin
                        state_q <= DIV_RUN;
                        cnt_q   <= DIV_CNT_W'(DIV_STEPS - 1);
                    end
                end
                DIV_RUN: begin
                    if (cnt_q == '0) begin
                        state_q <= DIV_DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= DIV_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------

    // One restoring shift-subtract step
    assign partial = {rem_q, quo_q[XLEN-1]};
    assign diff    = partial - {1'b0, dvsr_q};
    assign fits    = partial >= {1'b0, dvsr_q};

    always_ff @(posedge clk_i) begin
        if (state_q == DIV_IDLE && request_i) begin
            // Setup on magnitudes
            rem_q   <= '0;
            quo_q   <= dvnd_neg ? -dividend_i : dividend_i;
            dvsr_q  <= dvsr_neg ? -divisor_i : divisor_i;
            // Divide by zero keeps an all-ones quotient
            q_neg_q <= (dvnd_neg ^ dvsr_neg) && (divisor_i != '0);
            r_neg_q <= dvnd_neg;
        end else if (state_q == DIV_RUN) begin
            rem_q <= fits ? diff[XLEN-1:0] : partial[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], fits};
        end
    end

    // Most negative / -1 falls out of the unsigned magnitudes
    assign quotient_o  = q_neg_q ? -quo_q : quo_q;
    assign remainder_o = r_neg_q ? -rem_q : rem_q;

    assign busy_o = (state_q == DIV_RUN);
    assign done_o = (state_q == DIV_DONE);

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import exe_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        kill_i,
    input  logic        request_i,
    input  instr_type_e instr_type_i,
    input  bus64_t      src1_i,
    input  bus64_t      src2_i,
    output bus64_t      result_o,
    output logic        busy_o,
    output logic        done_o
);

    logic                   src1_signed;
    logic                   src2_signed;
    logic                   src1_neg;
    logic                   src2_neg;
    logic [MUL_LATENCY-1:0] valid_q;

    // Stage one
    bus64_t                 mag1_q;
    bus64_t                 mag2_q;
    logic                   neg_q;
    logic                   sel_hi_q;

    // Stage two
    logic [2*XLEN-1:0]      prod_mag;
    logic [2*XLEN-1:0]      prod_q;
    logic                   sel_hi2_q;

    // MULHSU treats only src1 as signed
    assign src1_signed = (instr_type_i == MULH) || (instr_type_i == MULHSU);
    assign src2_signed = (instr_type_i == MULH);
    assign src1_neg    = src1_signed && src1_i[XLEN-1];
    assign src2_neg    = src2_signed && src2_i[XLEN-1];

    always_ff @(posedge clk_i) begin
        mag1_q   <= src1_neg ? -src1_i : src1_i;
        mag2_q   <= src2_neg ? -src2_i : src2_i;
        neg_q    <= src1_neg ^ src2_neg;
        sel_hi_q <= (instr_type_i != MUL);
    end

    assign prod_mag = mag1_q * mag2_q;

    always_ff @(posedge clk_i) begin
        prod_q    <= neg_q ? -prod_mag : prod_mag;
        sel_hi2_q <= sel_hi_q;
    end

    // Valid bit follows the operation through both stages
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_LATENCY-2:0], request_i};
        end
    end

    assign busy_o   = |valid_q[MUL_LATENCY-2:0];
    assign done_o   = valid_q[MUL_LATENCY-1];
    assign result_o = sel_hi2_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import exe_pkg::*; (
    input  instr_type_e instr_type_i,
    input  addr_pc_t    pc_i,
    input  bus64_t      rs1_i,
    input  bus64_t      rs2_i,
    input  bus64_t      imm_i,
    output logic        taken_o,
    output addr_pc_t    next_pc_o,
    output bus64_t      link_o
);

    addr_pc_t target;
    addr_pc_t pc_plus4;
    addr_pc_t jalr_sum;
    logic     is_jump;

    assign pc_plus4 = pc_i + XLEN'(4);
    assign jalr_sum = rs1_i + imm_i;
    assign is_jump  = (instr_type_i == JAL) || (instr_type_i == JALR);

    // JALR target drops bit 0
    assign target = (instr_type_i == JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                           : pc_i + imm_i;

    // Condition evaluation
    always_comb begin
        case (instr_type_i)
            BEQ:       taken_o = (rs1_i == rs2_i);
            BNE:       taken_o = (rs1_i != rs2_i);
            BLT:       taken_o = ($signed(rs1_i) <  $signed(rs2_i));
            BGE:       taken_o = ($signed(rs1_i) >= $signed(rs2_i));
            BLTU:      taken_o = (rs1_i <  rs2_i);
            BGEU:      taken_o = (rs1_i >= rs2_i);
            JAL, JALR: taken_o = 1'b1;
            default:   taken_o = 1'b0;
        endcase
    end

    assign next_pc_o = taken_o ? target : pc_plus4;

    // Return address for jumps only
    assign link_o = is_jump ? pc_plus4 : '0;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import exe_pkg::*; (
    input  bus64_t      src1_i,
    input  bus64_t      src2_i,
    input  instr_type_e instr_type_i,
    output bus64_t      result_o
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Only the low six bits count for 64-bit shifts
    assign shamt = src2_i[5:0];

    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (instr_type_i)
            ADD: begin
                result_o = src1_i + src2_i;
            end
            SUB: begin
                result_o = src1_i - src2_i;
            end
            AND: begin
                result_o = src1_i & src2_i;
            end
            OR: begin
                result_o = src1_i | src2_i;
            end
            XOR: begin
                result_o = src1_i ^ src2_i;
            end
            SLL: begin
                result_o = src1_i << shamt;
            end
            SRL: begin
                result_o = src1_i >> shamt;
            end
            SRA: begin
                result_o = bus64_t'($signed(src1_i) >>> shamt);
            end
            SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // Operations of the other units
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== common/exe_pkg.sv ====
package exe_pkg;

    // ----------------------------------------
    // Widths and latencies
    // ----------------------------------------

    // Integer data width
    localparam int XLEN = 64;

    // Cycles from a multiplier request to its result
    localparam int MUL_LATENCY = 2;

    // Quotient bits found per division, one per cycle
    localparam int DIV_STEPS = 64;

    // Width of the divider step counter
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // ----------------------------------------
    // Basic types
    // ----------------------------------------

    typedef logic [XLEN-1:0] bus64_t;
    typedef logic [XLEN-1:0] addr_pc_t;
    typedef logic [4:0]      reg_t;

    // Functional unit that executes the instruction
    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV,
        UNIT_BRANCH,
        UNIT_SYSTEM
    } unit_e;

    // Operation, grouped by the unit that runs it
    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU,
        // Multiplier
        MUL, MULH, MULHSU, MULHU,
        // Divider
        DIV, DIVU, REM, REMU,
        // Branch unit
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR
    } instr_type_e;

    // ----------------------------------------
    // Pipeline packets
    // ----------------------------------------

    // Decoded instruction
    typedef struct packed {
        logic        valid;
        addr_pc_t    pc;
        reg_t        rs1;
        reg_t        rs2;
        reg_t        rd;
        bus64_t      imm;
        logic        use_pc;
        logic        use_imm;
        unit_e       unit;
        instr_type_e instr_type;
    } exe_instr_t;

    // From register read, with operand values
    typedef struct packed {
        exe_instr_t instr;
        bus64_t     data_rs1;
        bus64_t     data_rs2;
    } rr_exe_instr_t;

    // Forwarding from write-back
    typedef struct packed {
        logic   valid;
        reg_t   rd;
        bus64_t data;
    } wb_exe_instr_t;

    // Result toward write-back
    typedef struct packed {
        logic     valid;
        reg_t     rd;
        bus64_t   result_rd;
        addr_pc_t result_pc;
        logic     branch_taken;
    } exe_wb_instr_t;

endpackage
